// ==== hdl/fetch_pkg.sv ====
// fetch and decode shared constants
`default_nettype none

package fetch_pkg;

    // data and address width
    localparam int unsigned XLEN = 32;

    // reset value of the program counter
    localparam logic [XLEN-1:0] PROG_START = 32'h0000_0000;

    // architectural register count
    localparam int unsigned NREGS = 32;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_IMM    = 7'b0010011;  // addi lives here
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 selects
    localparam logic [2:0] F3_ADDI = 3'b000;  // only addi among op-imm
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;

    // word pushed into decode when a slot is flushed
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0000;

    // kind of control transfer sitting in decode
    typedef enum logic [1:0]
    {
        NONE = 2'd0,  // plain instruction
        JAL  = 2'd1,  // unconditional jump
        BEQ  = 2'd2,  // branch if equal
        BNE  = 2'd3   // branch if not equal
    } branch_kind_t;

endpackage : fetch_pkg

`default_nettype wire

// ==== hdl/fetch_id_if.sv ====
// fetch to IF/ID link
`timescale 1ns/1ps
`default_nettype none

interface fetch_id_if (input logic stall_i);

    logic [fetch_pkg::XLEN-1:0] instr;  // fetched word or nop
    logic [fetch_pkg::XLEN-1:0] pc;     // address of that word
    logic                       flush;  // slot carries a bubble
    logic                       hold;   // IF/ID not taking a word this cycle
    logic                       stall;  // back-pressure seen by the stage

    assign stall = stall_i;

    modport fetch (output instr, output pc, output flush, input hold);

    modport stage (input instr, input pc, input flush, input stall, output hold);

endinterface : fetch_id_if

`default_nettype wire

// ==== hdl/branch_if.sv ====
// execute to fetch redirect link
`timescale 1ns/1ps
`default_nettype none

interface branch_if;

    logic [fetch_pkg::XLEN-1:0] pc_branch;  // redirect target
    logic                       pc_src;     // taken transfer in decode
    fetch_pkg::branch_kind_t    kind;       // what sits in decode
    logic                       stall;      // back-pressure level

    // execute resolves and drives everything
    modport exec
    (
        output pc_branch,
        output pc_src,
        output kind,
        output stall
    );

    modport fetch
    (
        input pc_branch,
        input pc_src,
        input kind,
        input stall
    );

endinterface : branch_if

`default_nettype wire

// ==== hdl/instr_fetch.sv ====
// instruction fetch unit
`timescale 1ns/1ps
`default_nettype none

module instr_fetch
(
    input  logic                       clk,
    input  logic                       resetn,
    output logic [fetch_pkg::XLEN-1:0] imem_addr_o,  // to instruction memory
    input  logic [fetch_pkg::XLEN-1:0] imem_rd_i,    // word for imem_addr_o, same cycle
    input  logic                       imem_ack_i,   // low means no word this cycle
    fetch_id_if.fetch                  fid,
    branch_if.fetch                    br
);
    logic [fetch_pkg::XLEN-1:0] pc_q;          // current fetch address
    logic [fetch_pkg::XLEN-1:0] pc_plus4;
    logic [fetch_pkg::XLEN-1:0] pc_next;
    logic                       pc_load;       // pc advances at this edge
    logic                       rst_flush_q;   // first cycle out of reset
    logic                       flush_branch;  // wrong-path word behind a taken branch
    logic                       flush_ack;     // memory gave nothing
    logic                       redir_q;       // taken target still to be loaded
    logic [fetch_pkg::XLEN-1:0] redir_pc_q;
    logic                       sel_q;         // feed the captured word
    logic                       cap_we;
    logic [fetch_pkg::XLEN-1:0] cap_word_q;    // word saved across a stall
    fetch_pkg::branch_kind_t    kind_q;        // decode kind one cycle late

    assign pc_plus4 = pc_q + 4;

    // target wins, then a parked target, then sequential
    always_comb
    begin
        if (br.pc_src)
            pc_next = br.pc_branch;
        else if (redir_q)
            pc_next = redir_pc_q;
        else
            pc_next = pc_plus4;
    end

    // hold on stall, on missing ack and during the reset slot
    assign pc_load = !br.stall && imem_ack_i && !rst_flush_q;

    assign flush_branch = br.pc_src && !br.stall;
    assign flush_ack    = !imem_ack_i;
    assign fid.flush    = rst_flush_q || flush_branch || flush_ack || redir_q;

    // save the word once per stall, not while a transfer resolves
    assign cap_we = fid.hold && !sel_q && imem_ack_i && (kind_q == fetch_pkg::NONE);

    assign fid.instr = fid.flush ? fetch_pkg::NOP_INSTR :
                       (sel_q ? cap_word_q : imem_rd_i);
    assign fid.pc      = pc_q;
    assign imem_addr_o = pc_q;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            pc_q        <= fetch_pkg::PROG_START;
            rst_flush_q <= 1'b1;  // bubble the first slot
        end
        else
        begin
            rst_flush_q <= 1'b0;
            if (pc_load)
                pc_q <= pc_next;
        end
    end

    // a taken transfer that met a low ack waits here
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            redir_q <= 1'b0;
        else if (br.pc_src && !imem_ack_i)
            redir_q <= 1'b1;
        else if (pc_load)
            redir_q <= 1'b0;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            sel_q  <= 1'b0;
            kind_q <= fetch_pkg::NONE;
        end
        else
        begin
            sel_q  <= fid.hold && (sel_q || cap_we);  // drops at the edge the stall ends
            kind_q <= br.kind;
        end
    end

    always_ff @(posedge clk)
    begin
        if (br.pc_src && !imem_ack_i)
            redir_pc_q <= br.pc_branch;
        if (cap_we)
            cap_word_q <= imem_rd_i;
    end

endmodule : instr_fetch

`default_nettype wire

// ==== hdl/if_id_stage.sv ====
// IF/ID pipeline register
`timescale 1ns/1ps
`default_nettype none

module if_id_stage
(
    input  logic                       clk,
    input  logic                       resetn,
    fetch_id_if.stage                  fid,
    output logic [fetch_pkg::XLEN-1:0] id_instr_o,  // word in decode
    output logic [fetch_pkg::XLEN-1:0] id_pc_o,     // its address
    output logic                       id_valid_o   // low for a bubble
);
    logic [fetch_pkg::XLEN-1:0] instr_q;
    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic                       valid_q;

    // decode not accepting means fetch must keep its word
    assign fid.hold = fid.stall;

    // low marks a bubble in decode
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            valid_q <= 1'b0;
        else if (!fid.hold)
            valid_q <= !fid.flush;  // flushed slot enters as a bubble
    end

    always_ff @(posedge clk)
    begin
        if (!fid.hold)
        begin
            instr_q <= fid.instr;  // fetch already put the nop on a flushed slot
            pc_q    <= fid.pc;
        end
    end

    assign id_instr_o = instr_q;
    assign id_pc_o    = pc_q;
    assign id_valid_o = valid_q;

endmodule : if_id_stage

`default_nettype wire

// ==== hdl/exec_stage.sv ====
// decode, execute and retire
`timescale 1ns/1ps
`default_nettype none

module exec_stage
(
    input  logic                       clk,
    input  logic                       resetn,
    input  logic [fetch_pkg::XLEN-1:0] id_instr_i,
    input  logic [fetch_pkg::XLEN-1:0] id_pc_i,
    input  logic                       id_valid_i,
    input  logic                       stall_i,      // back-pressure from outside
    branch_if.exec                     br,
    output logic                       ret_valid_o,  // one pulse per retired word
    output logic [fetch_pkg::XLEN-1:0] ret_pc_o,
    output logic [fetch_pkg::XLEN-1:0] ret_instr_o
);
    localparam int unsigned RAW = $clog2(fetch_pkg::NREGS);  // register index width

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [RAW-1:0]             rd;
    logic [RAW-1:0]             rs1;
    logic [RAW-1:0]             rs2;
    logic [fetch_pkg::XLEN-1:0] rs1_val;
    logic [fetch_pkg::XLEN-1:0] rs2_val;
    logic [fetch_pkg::XLEN-1:0] imm_i;
    logic [fetch_pkg::XLEN-1:0] imm_j;
    logic [fetch_pkg::XLEN-1:0] imm_b;
    logic                       is_addi;
    logic                       regs_eq;
    logic                       taken;
    logic                       fire;        // decode word leaves at this edge
    fetch_pkg::branch_kind_t    kind;
    logic [fetch_pkg::XLEN-1:0] rf [fetch_pkg::NREGS];  // register file

    assign opcode = id_instr_i[6:0];
    assign funct3 = id_instr_i[14:12];
    assign rd     = id_instr_i[11:7];
    assign rs1    = id_instr_i[19:15];
    assign rs2    = id_instr_i[24:20];

    // sign extended immediates
    assign imm_i = {{20{id_instr_i[31]}}, id_instr_i[31:20]};
    assign imm_j = {{12{id_instr_i[31]}}, id_instr_i[19:12], id_instr_i[20],
                    id_instr_i[30:21], 1'b0};
    assign imm_b = {{20{id_instr_i[31]}}, id_instr_i[7], id_instr_i[30:25],
                    id_instr_i[11:8], 1'b0};

    assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];  // x0 hard wired
    assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];
    assign regs_eq = (rs1_val == rs2_val);

    assign is_addi = (opcode == fetch_pkg::OP_IMM) && (funct3 == fetch_pkg::F3_ADDI);

    // only valid words name a transfer
    always_comb
    begin
        kind = fetch_pkg::NONE;
        if (id_valid_i)
        begin
            if (opcode == fetch_pkg::OP_JAL)
                kind = fetch_pkg::JAL;
            else if (opcode == fetch_pkg::OP_BRANCH && funct3 == fetch_pkg::F3_BEQ)
                kind = fetch_pkg::BEQ;
            else if (opcode == fetch_pkg::OP_BRANCH && funct3 == fetch_pkg::F3_BNE)
                kind = fetch_pkg::BNE;
        end
    end

    assign taken = (kind == fetch_pkg::JAL) ||
                   (kind == fetch_pkg::BEQ && regs_eq) ||
                   (kind == fetch_pkg::BNE && !regs_eq);

    assign fire = id_valid_i && !stall_i;

    assign br.kind      = kind;
    assign br.pc_src    = taken && fire;  // redirect only when it really leaves
    assign br.pc_branch = id_pc_i + ((kind == fetch_pkg::JAL) ? imm_j : imm_b);
    assign br.stall     = stall_i;

    // addi result lands as the word retires
    always_ff @(posedge clk)
    begin
        if (fire && is_addi && rd != '0)
            rf[rd] <= rs1_val + imm_i;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            ret_valid_o <= 1'b0;
        else
            ret_valid_o <= fire;  // single cycle pulse
    end

    always_ff @(posedge clk)
    begin
        if (fire)
        begin
            ret_pc_o    <= id_pc_i;
            ret_instr_o <= id_instr_i;
        end
    end

endmodule : exec_stage

`default_nettype wire

// ==== hdl/fetch_decode_top.sv ====
// fetch and decode front end
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_top
(
    input  logic                       clk,
    input  logic                       resetn,
    // instruction memory
    output logic [fetch_pkg::XLEN-1:0] imem_addr_o,
    input  logic [fetch_pkg::XLEN-1:0] imem_rd_i,
    input  logic                       imem_ack_i,
    // back-pressure level
    input  logic                       stall_i,
    // retire report
    output logic                       ret_valid_o,
    output logic [fetch_pkg::XLEN-1:0] ret_pc_o,
    output logic [fetch_pkg::XLEN-1:0] ret_instr_o
);
    logic [fetch_pkg::XLEN-1:0] id_instr;  // decode slot contents
    logic [fetch_pkg::XLEN-1:0] id_pc;
    logic                       id_valid;

    fetch_id_if fid (.stall_i(stall_i));  // fetch to IF/ID
    branch_if   br ();                    // execute back to fetch

    instr_fetch u_fetch
    (
        .clk         (clk),
        .resetn      (resetn),
        .imem_addr_o (imem_addr_o),
        .imem_rd_i   (imem_rd_i),
        .imem_ack_i  (imem_ack_i),
        .fid         (fid.fetch),
        .br          (br.fetch)
    );

    if_id_stage u_if_id
    (
        .clk        (clk),
        .resetn     (resetn),
        .fid        (fid.stage),
        .id_instr_o (id_instr),
        .id_pc_o    (id_pc),
        .id_valid_o (id_valid)
    );

    exec_stage u_exec
    (
        .clk         (clk),
        .resetn      (resetn),
        .id_instr_i  (id_instr),
        .id_pc_i     (id_pc),
        .id_valid_i  (id_valid),
        .stall_i     (stall_i),
        .br          (br.exec),
        .ret_valid_o (ret_valid_o),
        .ret_pc_o    (ret_pc_o),
        .ret_instr_o (ret_instr_o)
    );

endmodule : fetch_decode_top

`default_nettype wire

// ==== tests/tb_clock.sv ====
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
    output logic clk_o,
    output logic resetn_o
);
    localparam int HALF_PERIOD  = 50;  // 100 ns period
    localparam int RESET_CYCLES = 5;

    initial
    begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial
    begin
        resetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 resetn_o = 1'b1;  // release just after the edge
    end

endmodule : tb_clock

`default_nettype wire

// ==== tests/fetch_props.sv ====
// front end port timing checks
`timescale 1ns/1ps
`default_nettype none

module fetch_props
(
    input logic        clk,
    input logic        resetn,
    input logic [31:0] imem_addr_i,
    input logic        imem_ack_i,
    input logic        stall_i,
    input logic        ret_valid_i,
    input logic [31:0] ret_pc_i,
    input logic [31:0] ret_instr_i
);
    int          fails = 0;  // read by tb_top
    logic [31:0] last_pc;    // pc of the previous retire
    logic        last_seq;   // previous retire was no control transfer

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            last_pc  <= 32'd0;
            last_seq <= 1'b0;
        end
        else if (ret_valid_i)
        begin
            last_pc  <= ret_pc_i;
            last_seq <= (ret_instr_i[6:0] != fetch_pkg::OP_JAL) &&
                        (ret_instr_i[6:0] != fetch_pkg::OP_BRANCH);
        end
    end

    // pc frozen by a stall or a missing ack
    a_addr_hold: assert property (@(posedge clk) disable iff (!resetn)
        (stall_i || !imem_ack_i) |=> $stable(imem_addr_i))
    else
    begin
        fails++;
        $error("fetch address moved while stalled or without ack");
    end

    a_stall_quiet: assert property (@(posedge clk) disable iff (!resetn)
        stall_i |=> !ret_valid_i)
    else
    begin
        fails++;
        $error("instruction retired during a stall");
    end

    // straight-line code steps by one word
    a_seq_step: assert property (@(posedge clk) disable iff (!resetn)
        (ret_valid_i && last_seq) |-> (ret_pc_i == last_pc + 32'd4))
    else
    begin
        fails++;
        $error("retired pc after a sequential instruction is not pc plus 4");
    end

endmodule : fetch_props

`default_nettype wire

// ==== tests/tb_top.sv ====
// fetch front end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    localparam int PROG_WORDS   = 15;
    localparam int N_RET        = 60;   // retirements to check
    localparam int RESET_CYCLES = 5;
    localparam int STALL_FACTOR = 8;    // worst case cycles per retirement
    localparam int PERIOD       = 100;

    logic        clk;
    logic        resetn;
    logic [31:0] imem_addr;
    logic [31:0] imem_rd;
    logic        imem_ack;
    logic        stall;
    logic        ret_valid;
    logic [31:0] ret_pc;
    logic [31:0] ret_instr;

    // program as meaning and as encoded words
    fetch_pkg::branch_kind_t p_kind [PROG_WORDS];  // NONE is addi here
    logic [4:0]              p_rd   [PROG_WORDS];
    logic [4:0]              p_rs1  [PROG_WORDS];
    logic [4:0]              p_rs2  [PROG_WORDS];
    logic [31:0]             p_imm  [PROG_WORDS];
    logic [31:0]             prog   [PROG_WORDS];
    logic [31:0]             regs   [32];           // model register file
    logic [31:0]             exp_pc;
    logic [31:0]             lfsr;
    string                   next_test;
    int                      errors;
    int                      retired;
    logic                    bit_a;
    logic                    bit_b;

    tb_clock clock_i (.clk_o(clk), .resetn_o(resetn));

    fetch_decode_top dut_i
    (
        .clk         (clk),
        .resetn      (resetn),
        .imem_addr_o (imem_addr),
        .imem_rd_i   (imem_rd),
        .imem_ack_i  (imem_ack),
        .stall_i     (stall),
        .ret_valid_o (ret_valid),
        .ret_pc_o    (ret_pc),
        .ret_instr_o (ret_instr)
    );

    bind fetch_decode_top fetch_props props_i
    (
        .clk         (clk),
        .resetn      (resetn),
        .imem_addr_i (imem_addr_o),
        .imem_ack_i  (imem_ack_i),
        .stall_i     (stall_i),
        .ret_valid_i (ret_valid_o),
        .ret_pc_i    (ret_pc_o),
        .ret_instr_i (ret_instr_o)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (addr < 32'(PROG_WORDS * 4))
            return prog[addr[5:2]];
        else
            return {addr[24:0] ^ addr[31:7], 7'b0};  // opcode 0 decodes as nop
    endfunction

    task automatic put(input int idx, input fetch_pkg::branch_kind_t k,
                       input int rd, input int rs1, input int rs2, input int imm);
        logic [2:0] f3;
        f3 = (k == fetch_pkg::BEQ) ? fetch_pkg::F3_BEQ : fetch_pkg::F3_BNE;
        p_kind[idx] = k;
        p_rd[idx]   = rd[4:0];
        p_rs1[idx]  = rs1[4:0];
        p_rs2[idx]  = rs2[4:0];
        p_imm[idx]  = imm;
        case (k)
            fetch_pkg::JAL:
                prog[idx] = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0],
                             fetch_pkg::OP_JAL};
            fetch_pkg::BEQ, fetch_pkg::BNE:
                prog[idx] = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1],
                             imm[11], fetch_pkg::OP_BRANCH};
            default:
                prog[idx] = {imm[11:0], rs1[4:0], fetch_pkg::F3_ADDI, rd[4:0],
                             fetch_pkg::OP_IMM};
        endcase
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act)
        else
        begin
            errors++;
            $display("** Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    // predicts the next retired pc from the instruction at exp_pc
    task automatic step_model();
        logic [3:0]  idx;
        logic [31:0] a;
        logic [31:0] b;
        logic        hit;
        idx = exp_pc[5:2];
        a   = regs[p_rs1[idx]];
        b   = regs[p_rs2[idx]];
        hit = (p_kind[idx] == fetch_pkg::BEQ) ? (a == b) : (a != b);
        case (p_kind[idx])
            fetch_pkg::JAL:
            begin
                next_test = "jal_target";
                exp_pc    = exp_pc + p_imm[idx];
            end
            fetch_pkg::BEQ, fetch_pkg::BNE:
            begin
                next_test = "branch_not_taken";
                if (hit)
                    next_test = "branch_taken";
                exp_pc = hit ? exp_pc + p_imm[idx] : exp_pc + 32'd4;
            end
            default:
            begin
                next_test = "addi_seq";
                if (p_rd[idx] != 5'd0)
                    regs[p_rd[idx]] = a + p_imm[idx];  // x0 stays zero
                exp_pc = exp_pc + 32'd4;
            end
        endcase
    endtask

    always_comb imem_rd = word_at(imem_addr);  // same cycle memory

    initial
    begin
        stall     = 1'b0;
        imem_ack  = 1'b1;
        lfsr      = 32'h756a_bdf8;
        errors    = 0;
        retired   = 0;
        exp_pc    = fetch_pkg::PROG_START;
        next_test = "reset_start";
        for (int i = 0; i < 32; i++)
            regs[i] = 32'd0;
        put(0, fetch_pkg::NONE, 1, 0, 0, 5);
        put(1, fetch_pkg::NONE, 2, 0, 0, 5);
        put(2, fetch_pkg::NONE, 3, 0, 0, 7);
        put(3, fetch_pkg::BEQ, 0, 1, 2, 8);   // equal, taken
        put(4, fetch_pkg::NONE, 4, 0, 0, 1);  // skipped
        put(5, fetch_pkg::BEQ, 0, 1, 3, 8);   // unequal, falls through
        put(6, fetch_pkg::BNE, 0, 1, 3, 8);   // unequal, taken
        put(7, fetch_pkg::NONE, 4, 0, 0, 2);  // skipped
        put(8, fetch_pkg::BNE, 0, 1, 2, 8);   // equal, falls through
        put(9, fetch_pkg::JAL, 0, 0, 0, 12);
        put(10, fetch_pkg::NONE, 5, 0, 0, 3); // jumped over
        put(11, fetch_pkg::NONE, 5, 0, 0, 4);
        put(12, fetch_pkg::NONE, 1, 1, 0, -1);  // count x1 down
        put(13, fetch_pkg::BNE, 0, 1, 0, -4);
        put(14, fetch_pkg::JAL, 0, 0, 0, -56);  // back to start
        @(posedge resetn);
        forever
        begin
            @(posedge clk);
            #1;
            draw_bit(bit_a);
            draw_bit(bit_b);
            stall = bit_a & bit_b;
            draw_bit(bit_a);
            draw_bit(bit_b);
            imem_ack = !(bit_a & bit_b);
        end
    end

    // outputs sampled mid cycle
    always @(negedge clk)
    begin
        if (!resetn)
        begin
            check("reset_addr", fetch_pkg::PROG_START, imem_addr);
            check("reset_quiet", 32'd0, {31'd0, ret_valid});
        end
        else if (ret_valid && retired < N_RET)  // stop at the last counted retire
        begin
            check(next_test, exp_pc, ret_pc);
            check("retire_word", word_at(exp_pc), ret_instr);
            step_model();
            retired++;
        end
    end

    initial
    begin
        wait (retired == N_RET);
        @(negedge clk);
        $display("errors: model %0d assertions %0d", errors, dut_i.props_i.fails);
        if (errors + dut_i.props_i.fails == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        #((RESET_CYCLES + N_RET * STALL_FACTOR) * PERIOD);
        $display("watchdog expired with only %0d instructions retired", retired);
        $display("** FAIL **");
        $finish;
    end

endmodule : tb_top

`default_nettype wire

// ==== filelist.f ====
hdl/fetch_pkg.sv
hdl/fetch_id_if.sv
hdl/branch_if.sv
hdl/instr_fetch.sv
hdl/if_id_stage.sv
hdl/exec_stage.sv
hdl/fetch_decode_top.sv
tests/tb_clock.sv
tests/fetch_props.sv
tests/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tb_top \
    -Mdir obj_dir -o tb_top_sim
status=0
out=$(./obj_dir/tb_top_sim +verilator+error+limit+1000 2>&1) || status=$?
printf '%s\n' "$out"
[ "$status" -eq 0 ] || exit "$status"
if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
